/* bench/tb_cam_int.sv */
`timescale 1ns/100ps

`include "cam_int_defs.svh"

module tb_cam_int
	import cam_int_pkg::*;
();

	// short interval so rate limiting is reachable in simulation
	localparam int INTERVAL      = 200;
	localparam int PAST_INTERVAL = INTERVAL + 20;
	localparam int FRAME_HIGH    = 12;
	// pin pulse width in clk cycles
	localparam int PULSE_WIDTH   = 16;
	// longest wait for one pin pulse to finish
	localparam int WAIT_LIMIT    = 200;

	logic        clk;
	logic        rst_n;
	logic        fval;
	reg_req_t    req;
	logic [31:0] rdata;
	logic        interrupt;

	// gap generator state
	logic [31:0] lfsr_q;
	string       test_name;
	int          err_cnt;
	int          tmo_cnt;
	// pin monitor results
	int          pulse_cnt;
	int          high_run;
	int          last_width;

	cam_int_top #(
		.INTERVAL (INTERVAL)
	) uut (
		.clk         (clk),
		.i_rst_n     (rst_n),
		.i_fval      (fval),
		.i_req       (req),
		.o_rdata     (rdata),
		.o_interrupt (interrupt)
	);

	always #5 clk = ~clk;

	// ----------------------------------------
	// pin monitor
	// ----------------------------------------
	// sampled on the falling edge away from DUT updates
	always @(negedge clk) begin
		if (interrupt === 1'b1) begin
			if (high_run == 0) begin
				pulse_cnt++;
			end
			high_run++;
		end else if (high_run != 0) begin
			last_width = high_run;
			high_run   = 0;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	// one lfsr step per bit
	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			value  = (value << 1) | int'(lfsr_q[0]);
		end
	endtask

	// status read-back with pending in 3:2 and reported in 1:0
	function automatic logic [31:0] status_word(input int_vec_t pend, input int_vec_t rep);
		logic [31:0] word;
		word      = 32'h0;
		word[3:2] = pend;
		word[1:0] = rep;
		return word;
	endfunction

	task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR: %s expected 0x%08h actual 0x%08h", test_name, expected, actual);
			err_cnt++;
		end
	endtask

	// inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// ----------------------------------------
	// bus and frame tasks
	// ----------------------------------------
	task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
		req.wr    = 1'b1;
		req.addr  = addr;
		req.wdata = data;
		next_cycle();
		req.wr    = 1'b0;
		req.wdata = '0;
	endtask

	// data is valid one cycle after rd
	task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
		req.rd   = 1'b1;
		req.addr = addr;
		next_cycle();
		req.rd   = 1'b0;
		data     = rdata;
	endtask

	// gap of 8 to 39 cycles
	task automatic send_frame(input int high_len);
		int gap;
		fval = 1'b1;
		idle(high_len);
		fval = 1'b0;
		draw_bits(5, gap);
		idle(8 + gap);
	endtask

	// until the given pulse has gone low again
	task automatic wait_pulses(input int target);
		int waited;
		waited = 0;
		while (!(pulse_cnt >= target && high_run == 0) && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!(pulse_cnt >= target && high_run == 0)) begin
			$display("%s: interrupt pulse %0d did not finish within %0d cycles",
				test_name, target, WAIT_LIMIT);
			tmo_cnt++;
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_qualify();
		logic [31:0] rd;
		test_name = "qualify";
		// everything zero out of reset
		check_equal(32'h0, {31'd0, interrupt});
		reg_read(`CAM_INT_ADDR_CTRL, rd);
		check_equal(32'h0, rd);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b00, 2'b00), rd);
		// frame already high when enables come on
		fval = 1'b1;
		idle(5);
		reg_write(`CAM_INT_ADDR_CTRL, 32'hf);
		idle(5);
		fval = 1'b0;
		idle(10);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b00, 2'b00), rd);
		check_equal(32'd0, pulse_cnt);
		// next full frame with both sources on
		send_frame(FRAME_HIGH);
		wait_pulses(1);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(32'h3, (rd >> 2) & 32'h3);
	endtask

	task automatic test_pulse();
		logic [31:0] rd;
		int          base;
		test_name = "pulse";
		base = pulse_cnt;
		idle(PAST_INTERVAL);
		send_frame(FRAME_HIGH);
		wait_pulses(base + 1);
		check_equal(base + 1, pulse_cnt);
		check_equal(PULSE_WIDTH, last_width);
		// both sources behind this pulse
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(32'h3, rd & 32'h3);
	endtask

	task automatic test_enables();
		logic [31:0] rd;
		int          base;
		test_name = "enables";
		// stream off first so a fresh rise is needed
		reg_write(`CAM_INT_ADDR_CTRL, 32'h0);
		idle(4);
		// acq and stream with white balance only
		reg_write(`CAM_INT_ADDR_CTRL, 32'hd);
		base = pulse_cnt;
		idle(PAST_INTERVAL);
		send_frame(FRAME_HIGH);
		wait_pulses(base + 1);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b10, 2'b10), rd);
		// no source enabled so no pin activity
		reg_write(`CAM_INT_ADDR_CTRL, 32'hc);
		base = pulse_cnt;
		idle(PAST_INTERVAL);
		repeat (3) send_frame(FRAME_HIGH);
		idle(30);
		check_equal(base, pulse_cnt);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b00, 2'b00), rd);
	endtask

	task automatic test_clear();
		logic [31:0] rd;
		int          base;
		test_name = "clear";
		reg_write(`CAM_INT_ADDR_CTRL, 32'hf);
		base = pulse_cnt;
		idle(PAST_INTERVAL);
		send_frame(FRAME_HIGH);
		wait_pulses(base + 1);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b11, 2'b11), rd);
		// clear grey only and keep wb
		reg_write(`CAM_INT_ADDR_CLEAR, 32'h1);
		idle(3);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b10, 2'b10), rd);
		reg_read(`CAM_INT_ADDR_CLEAR, rd);
		check_equal(32'h0, rd);
	endtask

	task automatic test_rate_limit();
		int base;
		test_name = "rate_limit";
		base = pulse_cnt;
		idle(PAST_INTERVAL);
		// two frame ends well inside one interval
		send_frame(FRAME_HIGH);
		send_frame(FRAME_HIGH);
		wait_pulses(base + 1);
		idle(40);
		check_equal(base + 1, pulse_cnt);
		// interval over with sources still pending
		idle(PAST_INTERVAL);
		send_frame(FRAME_HIGH);
		wait_pulses(base + 2);
		check_equal(base + 2, pulse_cnt);
	endtask

	task automatic test_stream_stop();
		logic [31:0] rd;
		test_name = "stream_stop";
		// grey was set again by the last frames
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b11, 2'b11), rd);
		// stream_en low with the rest kept
		reg_write(`CAM_INT_ADDR_CTRL, 32'hb);
		idle(4);
		reg_read(`CAM_INT_ADDR_STATUS, rd);
		check_equal(status_word(2'b00, 2'b00), rd);
		reg_read(`CAM_INT_ADDR_CTRL, rd);
		check_equal(32'hb, rd);
		reg_write(`CAM_INT_ADDR_CTRL, 32'h6);
		reg_read(`CAM_INT_ADDR_CTRL, rd);
		check_equal(32'h6, rd);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		fval       = 1'b0;
		req        = '0;
		lfsr_q     = 32'hc213;
		test_name  = "reset";
		err_cnt    = 0;
		tmo_cnt    = 0;
		pulse_cnt  = 0;
		high_run   = 0;
		last_width = 0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();

		test_qualify();
		test_pulse();
		test_enables();
		test_clear();
		test_rate_limit();
		test_stream_stop();

		$display("errors: %0d  timeouts: %0d", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+source
source/cam_int_pkg.sv
source/frame_qualifier.sv
source/int_status.sv
source/int_pacer.sv
source/int_reg_file.sv
source/cam_int_top.sv
bench/tb_cam_int.sv

/* run_sim.sh */
#!/bin/sh
# build and run the camera interrupt testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_cam_int
OBJ=obj_dir
LOG=sim.log

# compile the package, RTL and testbench into one binary
verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" \
	-f filelist.f \
	--Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# run, keep the output for the result search
"./$OBJ/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

# result decided by the log alone
if grep -q "^STATUS: PASS$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

/* source/cam_int_defs.svh */
`ifndef CAM_INT_DEFS_SVH
`define CAM_INT_DEFS_SVH

// ----------------------------------------
// register map
// ----------------------------------------
// control word, read and write
`define CAM_INT_ADDR_CTRL    2'd0
// write one to clear, reads as zero
`define CAM_INT_ADDR_CLEAR   2'd1
// reported in 1:0, pending in 3:2
`define CAM_INT_ADDR_STATUS  2'd2

// ----------------------------------------
// timing
// ----------------------------------------
// minimum spacing between pin pulses, 50 ms at 72 MHz
`define CAM_INT_INTERVAL_DFLT  3600000

// pin pulse width in clk cycles, 222 ns at 72 MHz
`define CAM_INT_PULSE_CYCLES   16

`endif

/* source/cam_int_pkg.sv */
package cam_int_pkg;

	// ----------------------------------------
	// control register
	// ----------------------------------------
	// bit 3 acq_start, bit 2 stream_en, bit 1 en_grey, bit 0 en_wb
	typedef struct packed {
		logic acq_start;
		logic stream_en;
		logic en_grey;
		logic en_wb;
	} cam_ctrl_t;

	// one bit per source, bit 0 grey, bit 1 white balance
	typedef logic [1:0] int_vec_t;

	// single-cycle register access, no handshake
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [1:0]  addr;
		logic [31:0] wdata;
	} reg_req_t;

	// ----------------------------------------
	// write word views
	// ----------------------------------------
	typedef struct packed {
		logic [27:0] rsvd;
		cam_ctrl_t   ctrl;
	} ctrl_word_t;

	typedef struct packed {
		logic [29:0] rsvd;
		int_vec_t    bits;
	} clr_word_t;

	// same bus word, meaning chosen by address
	typedef union packed {
		logic [31:0] raw;
		ctrl_word_t  ctrl;
		clr_word_t   clr;
	} reg_word_u;

	// frame events toward status and pacer
	typedef struct packed {
		logic full_frame;
		logic fall_d0;
		logic fall_d1;
	} frame_evt_t;

endpackage

/* source/cam_int_top.sv */
`timescale 1ns/100ps

`include "cam_int_defs.svh"

module cam_int_top
	import cam_int_pkg::*;
#(
	parameter int INTERVAL = `CAM_INT_INTERVAL_DFLT
) (
	input  logic        clk,
	input  logic        i_rst_n,
	// frame valid, already in the clk domain
	input  logic        i_fval,
	input  reg_req_t    i_req,
	output logic [31:0] o_rdata,
	// active high, to the host
	output logic        o_interrupt
);

	cam_ctrl_t  ctrl;
	int_vec_t   clr;
	frame_evt_t evt;
	int_vec_t   pending;
	int_vec_t   reported;
	logic       int_issue;

	// ----------------------------------------
	// frame qualification
	// ----------------------------------------
	frame_qualifier u_frame_qualifier (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_fval  (i_fval),
		.i_ctrl  (ctrl),
		.o_evt   (evt)
	);

	// ----------------------------------------
	// internal and interface status
	// ----------------------------------------
	int_status u_int_status (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_ctrl      (ctrl),
		.i_evt       (evt),
		.i_clr       (clr),
		.i_int_issue (int_issue),
		.o_pending   (pending),
		.o_reported  (reported)
	);

	// interval and pin stretch
	int_pacer #(
		.INTERVAL (INTERVAL)
	) u_int_pacer (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_evt       (evt),
		.i_pending   (pending),
		.o_int_issue (int_issue),
		.o_interrupt (o_interrupt)
	);

	// register front end
	int_reg_file u_int_reg_file (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_req      (i_req),
		.i_pending  (pending),
		.i_reported (reported),
		.o_ctrl     (ctrl),
		.o_clr      (clr),
		.o_rdata    (o_rdata)
	);

endmodule

/* source/frame_qualifier.sv */
`timescale 1ns/100ps

module frame_qualifier
	import cam_int_pkg::*;
(
	input  logic       clk,
	input  logic       i_rst_n,
	input  logic       i_fval,
	input  cam_ctrl_t  i_ctrl,
	output frame_evt_t o_evt
);

	// two-stage frame valid history
	logic [1:0] fval_hist;
	// registered edges
	logic       fval_rise;
	logic       fval_fall;
	// rise seen under enable
	logic       rise_seen;
	logic       full_frame;
	logic       fall_d0;
	logic       fall_d1;
	logic       stream_on;

	// both acquisition and stream must be on
	assign stream_on = i_ctrl.acq_start & i_ctrl.stream_en;

	// ----------------------------------------
	// edge detect
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fval_hist <= 2'b00;
			fval_rise <= 1'b0;
			fval_fall <= 1'b0;
			fall_d0   <= 1'b0;
			fall_d1   <= 1'b0;
		end else begin
			fval_hist <= {fval_hist[0], i_fval};
			// edges land one cycle after the history shows them
			fval_rise <= (fval_hist == 2'b01);
			fval_fall <= (fval_hist == 2'b10);
			// d0 orders the status stage, d1 the issue stage
			fall_d0   <= fval_fall;
			fall_d1   <= fall_d0;
		end
	end

	// ----------------------------------------
	// complete frame tracking
	// ----------------------------------------
	// a frame already running when enables come on has no rise here
	always_ff @(posedge clk) begin
		if (!i_rst_n || !stream_on) begin
			rise_seen <= 1'b0;
		end else if (fval_rise) begin
			rise_seen <= 1'b1;
		end
	end

	// only a fall after a qualified rise completes a frame
	always_ff @(posedge clk) begin
		if (!i_rst_n || !stream_on || !rise_seen) begin
			full_frame <= 1'b0;
		end else if (fval_fall) begin
			full_frame <= 1'b1;
		end
	end

	assign o_evt.full_frame = full_frame;
	assign o_evt.fall_d0    = fall_d0;
	assign o_evt.fall_d1    = fall_d1;

endmodule

/* source/int_pacer.sv */
`timescale 1ns/100ps

`include "cam_int_defs.svh"

module int_pacer
	import cam_int_pkg::*;
#(
	parameter int INTERVAL = `CAM_INT_INTERVAL_DFLT
) (
	input  logic       clk,
	input  logic       i_rst_n,
	input  frame_evt_t i_evt,
	input  int_vec_t   i_pending,
	output logic       o_int_issue,
	output logic       o_interrupt
);

	localparam int CNT_W   = $clog2(INTERVAL + 1);
	localparam int PULSE   = `CAM_INT_PULSE_CYCLES;
	localparam int PULSE_W = $clog2(PULSE + 1);

	// ----------------------------------------
	// interval
	// ----------------------------------------
	// time since last issue, holds at INTERVAL
	logic [CNT_W-1:0]   gap_cnt;
	logic               time_up;
	logic               int_issue;
	// pin stretch, idles at PULSE
	logic [PULSE_W-1:0] pulse_cnt;
	logic               int_pin;

	// starts saturated so the first good frame end fires
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			gap_cnt <= CNT_W'(INTERVAL);
		end else if (int_issue) begin
			gap_cnt <= '0;
		end else if (gap_cnt != CNT_W'(INTERVAL)) begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			time_up <= 1'b1;
		end else begin
			time_up <= (gap_cnt == CNT_W'(INTERVAL));
		end
	end

	// ----------------------------------------
	// issue decision
	// ----------------------------------------
	// frame ends inside the interval are dropped, not queued
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			int_issue <= 1'b0;
		end else begin
			int_issue <= time_up & i_evt.fall_d1 & (|i_pending);
		end
	end

	// ----------------------------------------
	// pulse stretch
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pulse_cnt <= PULSE_W'(PULSE);
		end else if (int_issue) begin
			pulse_cnt <= '0;
		end else if (pulse_cnt != PULSE_W'(PULSE)) begin
			pulse_cnt <= pulse_cnt + 1'b1;
		end
	end

	// high while the stretch counter runs, one stage late
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			int_pin <= 1'b0;
		end else begin
			int_pin <= (pulse_cnt != PULSE_W'(PULSE));
		end
	end

	assign o_int_issue = int_issue;
	assign o_interrupt = int_pin;

endmodule

/* source/int_reg_file.sv */
`timescale 1ns/100ps

`include "cam_int_defs.svh"

module int_reg_file
	import cam_int_pkg::*;
(
	input  logic        clk,
	input  logic        i_rst_n,
	input  reg_req_t    i_req,
	input  int_vec_t    i_pending,
	input  int_vec_t    i_reported,
	output cam_ctrl_t   o_ctrl,
	output int_vec_t    o_clr,
	output logic [31:0] o_rdata
);

	// incoming write word, two decodes
	reg_word_u   wr_word;
	logic        wr_ctrl;
	logic        wr_clear;
	cam_ctrl_t   ctrl_q;
	int_vec_t    clr_q;
	// read mux ahead of the data register
	logic [31:0] rd_mux;
	logic [31:0] rdata_q;

	assign wr_word.raw = i_req.wdata;
	assign wr_ctrl     = i_req.wr && (i_req.addr == `CAM_INT_ADDR_CTRL);
	assign wr_clear    = i_req.wr && (i_req.addr == `CAM_INT_ADDR_CLEAR);

	// ----------------------------------------
	// control register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			ctrl_q <= wr_word.ctrl.ctrl;
		end
	end

	// ----------------------------------------
	// clear strobes
	// ----------------------------------------
	// one cycle, only the bits written as one
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			clr_q <= '0;
		end else if (wr_clear) begin
			clr_q <= wr_word.clr.bits;
		end else begin
			clr_q <= '0;
		end
	end

	// ----------------------------------------
	// read back
	// ----------------------------------------
	always_comb begin
		rd_mux = '0;
		case (i_req.addr)
			`CAM_INT_ADDR_CTRL: begin
				rd_mux = {28'd0, ctrl_q};
			end
			`CAM_INT_ADDR_STATUS: begin
				// pending above reported
				rd_mux = {28'd0, i_pending, i_reported};
			end
			// clear and unused addresses read zero
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	// data one cycle after rd, held until the next read
	always_ff @(posedge clk) begin
		if (i_req.rd) begin
			rdata_q <= rd_mux;
		end
	end

	assign o_ctrl  = ctrl_q;
	assign o_clr   = clr_q;
	assign o_rdata = rdata_q;

endmodule

/* source/int_status.sv */
`timescale 1ns/100ps

module int_status
	import cam_int_pkg::*;
(
	input  logic       clk,
	input  logic       i_rst_n,
	input  cam_ctrl_t  i_ctrl,
	input  frame_evt_t i_evt,
	// one-cycle write-one clear
	input  int_vec_t   i_clr,
	// pin pulse decided this cycle
	input  logic       i_int_issue,
	output int_vec_t   o_pending,
	output int_vec_t   o_reported
);

	// per-source enables, same bit order as int_vec_t
	int_vec_t src_en;
	// internal state, raised at frame end
	int_vec_t pending;
	// interface state, what software sees
	int_vec_t reported;

	assign src_en = {i_ctrl.en_wb, i_ctrl.en_grey};

	// ----------------------------------------
	// pending bits
	// ----------------------------------------
	// no complete frame or source off forces the bit low
	// frame end beats a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pending <= '0;
		end else begin
			for (int j = 0; j < 2; j++) begin
				if (!i_evt.full_frame || !src_en[j]) begin
					pending[j] <= 1'b0;
				end else if (i_evt.fall_d0) begin
					pending[j] <= 1'b1;
				end else if (i_clr[j]) begin
					pending[j] <= 1'b0;
				end
			end
		end
	end

	// ----------------------------------------
	// reported bits
	// ----------------------------------------
	// latched only on a real pin pulse
	// so status lists exactly the sources behind it
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			reported <= '0;
		end else begin
			for (int j = 0; j < 2; j++) begin
				if (!pending[j]) begin
					// follows pending down, incl. via clear
					reported[j] <= 1'b0;
				end else if (i_int_issue) begin
					reported[j] <= 1'b1;
				end
			end
		end
	end

	assign o_pending  = pending;
	assign o_reported = reported;

endmodule
